//--- Bender.yml
package:
  name: ldpc_dec

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/ldpc_pkg.sv
      - design/wb_host_if.sv
      - design/layer_sched.sv
      - design/llr_mem.sv
      - design/ext_mem.sv
      - design/rcu_pipe.sv
      - design/ldpc_dec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/ldpc_dec_properties.sv
      - tb/ldpc_dec_tb.sv

//--- design/ext_mem.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// extrinsic storage, bank per layer
module ext_mem (
  input  logic                   clk,
  input  ldpc_pkg::row_t         rd_row,
  input  logic                   rd_lyr,
  input  ldpc_pkg::lane_mask_t   rd_en,
  output ldpc_pkg::llr_vec_t     rd_data,
  input  ldpc_pkg::rcu_ctl_t     wr_ctl,
  input  ldpc_pkg::llr_vec_t     wr_data
);

  localparam int W = `LDPC_LLR_W;

  ldpc_pkg::llr_vec_t mem [2*`LDPC_ROWDEPTH];  // layer 0 rows, then layer 1

  always_ff @(posedge clk) begin
    for (int i = 0; i < `LDPC_P; i++) begin
      // gated lanes read as zero
      rd_data[i*W +: W] <= rd_en[i] ? mem[rd_lyr*`LDPC_ROWDEPTH + rd_row][i*W +: W] : '0;
      if (wr_ctl.en[i])
        mem[wr_ctl.lyr*`LDPC_ROWDEPTH + wr_ctl.row][i*W +: W] <= wr_data[i*W +: W];
    end
  end

endmodule

//--- design/layer_sched.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// walks rows of layer 0, waits out the pipe, then layer 1, for all iterations
module layer_sched (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   loaden,
  output logic                   ready,
  output logic                   rd_l,
  output ldpc_pkg::row_t         row,
  output logic                   lyr,
  output ldpc_pkg::lane_mask_t   rd_e,
  output ldpc_pkg::lane_mask_t   lane_en
);

  localparam int PCNT_W = $clog2(`LDPC_PIPESTAGES);
  localparam ldpc_pkg::row_t LAST_ROW = ldpc_pkg::row_t'(`LDPC_ROWDEPTH - 1);
  // only the low P_LAST lanes carry data in the last row
  localparam ldpc_pkg::lane_mask_t LAST_MASK =
    ldpc_pkg::lane_mask_t'((1 << `LDPC_P_LAST) - 1);

  ldpc_pkg::sched_state_t  state;
  logic [PCNT_W-1:0]       pcnt;     // pipe wait counter
  logic [`LDPC_ITR_W-1:0]  itr;      // iteration counter

  //////////////////////////////
  // lane enables
  //////////////////////////////
  always_comb begin
    if (!rd_l)
      lane_en = '0;
    else if (row == LAST_ROW)
      lane_en = LAST_MASK;
    else
      lane_en = '1;
  end

  // e memory holds garbage from earlier runs, so skip it in iteration 0
  assign rd_e = (itr == '0) ? '0 : lane_en;

  //////////////////////////////
  // state and counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || loaden) begin  // load aborts like a reset
      state <= ldpc_pkg::INIT;
      ready <= 1'b0;
      rd_l  <= 1'b0;
      itr   <= '0;
      lyr   <= 1'b0;
      pcnt  <= '0;
      row   <= '0;
    end else begin
      case (state)
        ldpc_pkg::INIT: begin
          if (start) begin
            state <= ldpc_pkg::LYR0;
            ready <= 1'b0;
            rd_l  <= 1'b1;  // first row read next cycle
            itr   <= '0;
            lyr   <= 1'b0;
            pcnt  <= '0;
            row   <= '0;
          end
        end
        ldpc_pkg::LYR0, ldpc_pkg::LYR1: begin
          if (row < LAST_ROW) begin
            row <= row + 1'b1;
          end else begin
            rd_l  <= 1'b0;  // layer issued, drain the lanes
            pcnt  <= '0;
            state <= (state == ldpc_pkg::LYR0) ? ldpc_pkg::LYR0_WAIT : ldpc_pkg::LYR1_WAIT;
          end
        end
        ldpc_pkg::LYR0_WAIT: begin
          if (pcnt < PCNT_W'(`LDPC_PIPESTAGES - 1)) begin
            pcnt <= pcnt + 1'b1;
          end else begin
            state <= ldpc_pkg::LYR1;
            lyr   <= 1'b1;
            rd_l  <= 1'b1;
            row   <= '0;
          end
        end
        ldpc_pkg::LYR1_WAIT: begin
          if (pcnt < PCNT_W'(`LDPC_PIPESTAGES - 1)) begin
            pcnt <= pcnt + 1'b1;
          end else begin
            lyr <= 1'b0;
            row <= '0;
            if (itr < `LDPC_ITR_W'(`LDPC_MAXITRS - 1)) begin
              itr   <= itr + 1'b1;  // next iteration, back to layer 0
              state <= ldpc_pkg::LYR0;
              rd_l  <= 1'b1;
            end else begin
              state <= ldpc_pkg::INIT;
              ready <= 1'b1;        // run done
            end
          end
        end
        default: state <= ldpc_pkg::INIT;
      endcase
    end
  end

endmodule

//--- design/ldpc_dec_top.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

module ldpc_dec_top (
  input  logic         clk,
  input  logic         rst,
  input  logic         cyc,
  input  logic         stb,
  input  logic         we,
  input  logic [7:0]   adr,
  input  logic [31:0]  dat_w,
  output logic [31:0]  dat_r,
  output logic         ack
);

  // host side
  logic                          ready, loaden, start, host_we;
  ldpc_pkg::row_t                host_row;
  logic [$clog2(`LDPC_P)-1:0]    host_lane;
  ldpc_pkg::llr_t                host_wdata, host_rdata;
  // scheduler
  logic                          rd_l, lyr;
  ldpc_pkg::row_t                row;
  ldpc_pkg::lane_mask_t          rd_e, lane_en;
  // datapath
  ldpc_pkg::llr_vec_t            l_rd, e_rd, l_wb, e_wb;
  ldpc_pkg::rcu_ctl_t            ctl_q, wb_ctl;

  wb_host_if u_host (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .ready(ready),
    .host_rdata(host_rdata), .host_we(host_we), .host_row(host_row),
    .host_lane(host_lane), .host_wdata(host_wdata), .loaden(loaden), .start(start)
  );

  layer_sched u_sched (
    .clk(clk), .rst(rst), .start(start), .loaden(loaden), .ready(ready),
    .rd_l(rd_l), .row(row), .lyr(lyr), .rd_e(rd_e), .lane_en(lane_en)
  );

  //////////////////////////////
  // memories and lanes
  //////////////////////////////
  llr_mem u_lmem (
    .clk(clk), .host_we(host_we), .host_row(host_row), .host_lane(host_lane),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .rd(rd_l), .rd_row(row),
    .rd_data(l_rd), .wr_ctl(wb_ctl), .wr_data(l_wb)
  );

  ext_mem u_emem (
    .clk(clk), .rd_row(row), .rd_lyr(lyr), .rd_en(rd_e), .rd_data(e_rd),
    .wr_ctl(wb_ctl), .wr_data(e_wb)
  );

  // control lines up with registered memory data
  always_ff @(posedge clk) begin
    if (rst)
      ctl_q <= '0;
    else
      ctl_q <= '{row: row, lyr: lyr, en: lane_en};
  end

  rcu_pipe u_rcu (
    .clk(clk), .rst(rst), .l_in(l_rd), .e_in(e_rd), .ctl_in(ctl_q),
    .l_out(l_wb), .e_out(e_wb), .wb_ctl(wb_ctl)
  );

endmodule

//--- design/ldpc_pkg.sv
`include "ldpc_defines.svh"

package ldpc_pkg;

  // plain vectors with meaning
  typedef logic signed [`LDPC_LLR_W-1:0] llr_t;           // one llr
  typedef logic [`LDPC_ROW_W-1:0] row_t;                  // row address within a layer
  typedef logic [`LDPC_P-1:0] lane_mask_t;                // one bit per lane
  typedef logic [`LDPC_P*`LDPC_LLR_W-1:0] llr_vec_t;      // full row, lane 0 at lsb

  // address generation fsm
  typedef enum logic [2:0] {
    INIT,
    LYR0,
    LYR0_WAIT,
    LYR1,
    LYR1_WAIT
  } sched_state_t;

  // control word riding along with the lane data
  typedef struct packed {
    row_t       row;  // write-back row
    logic       lyr;  // write-back layer, selects e bank
    lane_mask_t en;   // lanes allowed to write
  } rcu_ctl_t;

endpackage

//--- design/llr_mem.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// channel llr storage, one row per address
module llr_mem (
  input  logic                             clk,
  input  logic                             host_we,
  input  ldpc_pkg::row_t                   host_row,
  input  logic [$clog2(`LDPC_P)-1:0]       host_lane,
  input  ldpc_pkg::llr_t                   host_wdata,
  output ldpc_pkg::llr_t                   host_rdata,
  input  logic                             rd,
  input  ldpc_pkg::row_t                   rd_row,
  output ldpc_pkg::llr_vec_t               rd_data,
  input  ldpc_pkg::rcu_ctl_t               wr_ctl,
  input  ldpc_pkg::llr_vec_t               wr_data
);

  localparam int W = `LDPC_LLR_W;

  ldpc_pkg::llr_vec_t mem [`LDPC_ROWDEPTH];

  //////////////////////////////
  // write and read ports
  //////////////////////////////
  always_ff @(posedge clk) begin
    // decoder write-back, per lane
    for (int i = 0; i < `LDPC_P; i++) begin
      if (wr_ctl.en[i])
        mem[wr_ctl.row][i*W +: W] <= wr_data[i*W +: W];
    end
    // host last, wins a same-lane clash
    if (host_we)
      mem[host_row][host_lane*W +: W] <= host_wdata;

    if (rd)
      rd_data <= mem[rd_row];  // decoder read, data next cycle
    host_rdata <= mem[host_row][host_lane*W +: W];
  end

endmodule

//--- design/rcu_pipe.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// row of lanes, two register stages, control travels alongside
module rcu_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  ldpc_pkg::llr_vec_t   l_in,
  input  ldpc_pkg::llr_vec_t   e_in,
  input  ldpc_pkg::rcu_ctl_t   ctl_in,
  output ldpc_pkg::llr_vec_t   l_out,
  output ldpc_pkg::llr_vec_t   e_out,
  output ldpc_pkg::rcu_ctl_t   wb_ctl
);

  localparam int W = `LDPC_LLR_W;
  localparam logic signed [W:0] MAXV = (1 <<< (W - 1)) - 1;  // +127
  localparam logic signed [W:0] MINV = -(1 <<< (W - 1));     // -128

  ldpc_pkg::rcu_ctl_t ctl_s1;

  // clamp one extra bit back into llr range
  function automatic ldpc_pkg::llr_t sat(input logic signed [W:0] x);
    if (x > MAXV)
      return MAXV[W-1:0];
    else if (x < MINV)
      return MINV[W-1:0];
    return x[W-1:0];
  endfunction

  //////////////////////////////
  // lanes
  //////////////////////////////
  for (genvar i = 0; i < `LDPC_P; i++) begin : g_lane
    ldpc_pkg::llr_t    l_old, e_old, d_q, e_new, e_q, l_q;
    logic signed [W:0] diff, sum;

    assign l_old = l_in[i*W +: W];
    assign e_old = e_in[i*W +: W];
    assign diff  = l_old - e_old;     // strip old extrinsic
    assign e_new = d_q >>> 1;         // stand-in update, half of d
    assign sum   = d_q + e_new;

    always_ff @(posedge clk) begin
      d_q <= sat(diff);  // stage 1
      e_q <= e_new;      // stage 2
      l_q <= sat(sum);
    end

    assign l_out[i*W +: W] = l_q;
    assign e_out[i*W +: W] = e_q;
  end

  // control pipe, cleared so nothing writes back out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_s1 <= '0;
      wb_ctl <= '0;
    end else begin
      ctl_s1 <= ctl_in;
      wb_ctl <= ctl_s1;
    end
  end

endmodule

//--- design/wb_host_if.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// wishbone classic slave, llr window plus ctrl and status
module wb_host_if (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [7:0]                   adr,
  input  logic [31:0]                  dat_w,
  output logic [31:0]                  dat_r,
  output logic                         ack,
  input  logic                         ready,
  input  ldpc_pkg::llr_t               host_rdata,
  output logic                         host_we,
  output ldpc_pkg::row_t               host_row,
  output logic [$clog2(`LDPC_P)-1:0]   host_lane,
  output ldpc_pkg::llr_t               host_wdata,
  output logic                         loaden,
  output logic                         start
);

  localparam int W = `LDPC_LLR_W;
  localparam int LANE_W = $clog2(`LDPC_P);

  logic req;      // new cycle, not yet acked
  logic in_win;   // address inside llr window
  logic sel_llr;  // read phase selects
  logic sel_stat;

  //////////////////////////////
  // address decode
  //////////////////////////////
  assign req        = cyc & stb & ~ack;
  assign in_win     = adr < 8'(`LDPC_ROWDEPTH * `LDPC_P);
  assign host_row   = ldpc_pkg::row_t'(adr / `LDPC_P);  // word = row*P + lane
  assign host_lane  = LANE_W'(adr % `LDPC_P);
  assign host_wdata = dat_w[W-1:0];
  assign host_we    = req & we & in_win;

  // ack and strobes one cycle after the request is seen
  always_ff @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      loaden   <= 1'b0;
      start    <= 1'b0;
      sel_llr  <= 1'b0;
      sel_stat <= 1'b0;
    end else begin
      ack      <= req;
      loaden   <= host_we;  // any llr write aborts a run
      start    <= req & we & (adr == `LDPC_ADR_CTRL) & dat_w[0];
      sel_llr  <= req & ~we & in_win;
      sel_stat <= req & ~we & (adr == `LDPC_ADR_STAT);
    end
  end

  //////////////////////////////
  // read mux, valid with ack
  //////////////////////////////
  always_comb begin
    if (sel_llr)
      dat_r = {{(32-W){host_rdata[W-1]}}, host_rdata};  // sign extend
    else if (sel_stat)
      dat_r = {31'b0, ready};
    else
      dat_r = '0;  // unmapped
  end

endmodule

//--- include/ldpc_defines.svh
`ifndef LDPC_DEFINES_SVH
`define LDPC_DEFINES_SVH

//////////////////////////////
// decoder geometry
//////////////////////////////
`define LDPC_P          4     // lanes per row
`define LDPC_ROWDEPTH   5     // rows per layer
`define LDPC_P_LAST     2     // valid lanes in last row
`define LDPC_LLR_W      8     // signed llr width
`define LDPC_ROW_W      3     // row address width
`define LDPC_ITR_W      2     // iteration counter width

//////////////////////////////
// schedule
//////////////////////////////
// wait after a layer's last row, 3 cycle read-to-write plus one spare
`define LDPC_PIPESTAGES 4
`define LDPC_MAXITRS    3     // iterations per run

//////////////////////////////
// host register map, word addresses
//////////////////////////////
`define LDPC_ADR_CTRL   8'h40 // bit 0 write = start
`define LDPC_ADR_STAT   8'h41 // bit 0 = ready

`endif

//--- tb/ldpc_dec_properties.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

// protocol and scheduler rules, bound into ldpc_dec_top
module ldpc_dec_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    cyc,
  input logic                    stb,
  input logic                    ack,
  input logic                    ready,
  input logic                    rd_l,
  input ldpc_pkg::rcu_ctl_t      wb_ctl,
  input ldpc_pkg::llr_vec_t      e_rd,
  input logic [`LDPC_ITR_W-1:0]  itr
);

  localparam ldpc_pkg::row_t LAST_ROW = ldpc_pkg::row_t'(`LDPC_ROWDEPTH - 1);
  localparam ldpc_pkg::lane_mask_t LAST_MASK =
    ldpc_pkg::lane_mask_t'((1 << `LDPC_P_LAST) - 1);

  //////////////////////////////
  // host bus
  //////////////////////////////
  ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(cyc && stb))
    else $error("ack raised without cyc and stb");

  //////////////////////////////
  // scheduler
  //////////////////////////////
  idle_not_reading: assert property (@(posedge clk) disable iff (rst)
    !(ready && rd_l))
    else $error("ready and rd_l high together");

  // dead lanes of the last row never reach write-back
  last_row_mask: assert property (@(posedge clk) disable iff (rst)
    (wb_ctl.row == LAST_ROW && wb_ctl.en != '0) |-> (wb_ctl.en == LAST_MASK))
    else $error("last row lane mask wrong at write-back");

  // e data into the lanes stays zero through iteration 0
  first_itr_no_e: assert property (@(posedge clk) disable iff (rst)
    $past(itr == '0) |-> (e_rd == '0))
    else $error("e memory data used in iteration 0");

endmodule

//--- tb/ldpc_dec_tb.sv
`timescale 1ns/1ns
`include "ldpc_defines.svh"

module ldpc_dec_tb;

  localparam int W       = `LDPC_LLR_W;
  localparam int P       = `LDPC_P;
  localparam int DEPTH   = `LDPC_ROWDEPTH;
  localparam int WORDS   = DEPTH * P;
  localparam int RUN_CYC = `LDPC_MAXITRS * 2 * (DEPTH + `LDPC_PIPESTAGES);
  localparam int BUS_CYC = 3;  // cycles per wishbone access
  localparam int N_TESTS = 6;
  // per entry up to three runs plus loads and read-backs, then x2 margin
  localparam int LIMIT   = (N_TESTS * (3 * RUN_CYC + 4 * WORDS * BUS_CYC) + 200) * 2;
  localparam int MAXV    = (1 << (W - 1)) - 1;
  localparam int MINV    = -(1 << (W - 1));

  typedef enum {PAT_RANDOM, PAT_POS100, PAT_NEG128, PAT_ZERO, PAT_ALT} pat_kind_t;
  typedef struct {
    string     name;
    pat_kind_t kind;
    bit        abort;  // kill a running decode with an llr write first
  } test_entry_t;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [7:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  test_entry_t tests [N_TESTS];
  int          loaded [DEPTH][P];    // values as written by the host
  int          l_mod [DEPTH][P];     // reference model state
  int          e_mod [2][DEPTH][P];
  int          cycles = 0;

  ldpc_dec_top dut0 (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  bind ldpc_dec_top ldpc_dec_properties u_props (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .ready(ready),
    .rd_l(rd_l), .wb_ctl(wb_ctl), .e_rd(e_rd), .itr(u_sched.itr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout waiting for ready");
      $display("TEST FAILED");
      $fatal(1, "cycle limit %0d reached", LIMIT);
    end
  end

  //////////////////////////////
  // checker and bus tasks
  //////////////////////////////
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, $signed(exp), $signed(act));
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic wb_write(input logic [7:0] a, input logic [31:0] d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    do @(negedge clk); while (!ack);  // ack settled by the falling edge
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [7:0] a, output logic [31:0] d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    do @(negedge clk); while (!ack);
    d = dat_r;  // read mux valid alongside ack
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic int clamp_llr(input int x);
    if (x > MAXV)
      return MAXV;
    if (x < MINV)
      return MINV;
    return x;
  endfunction

  // e starts at zero every run
  task automatic model_decode();
    int d;
    int e_new;
    foreach (e_mod[k, r, l])
      e_mod[k][r][l] = 0;
    for (int it = 0; it < `LDPC_MAXITRS; it++) begin
      for (int k = 0; k < 2; k++) begin
        for (int r = 0; r < DEPTH; r++) begin
          for (int l = 0; l < P; l++) begin
            if (r == DEPTH - 1 && l >= `LDPC_P_LAST)
              continue;  // dead lanes of the last row
            d = clamp_llr(l_mod[r][l] - e_mod[k][r][l]);
            e_new = d >>> 1;
            l_mod[r][l] = clamp_llr(d + e_new);
            e_mod[k][r][l] = e_new;
          end
        end
      end
    end
  endtask

  //////////////////////////////
  // test steps
  //////////////////////////////
  task automatic load_pattern(input pat_kind_t kind);
    int v;
    logic signed [W-1:0] b;
    for (int r = 0; r < DEPTH; r++) begin
      for (int l = 0; l < P; l++) begin
        b = W'($urandom);
        case (kind)
          PAT_RANDOM: v = b;
          PAT_POS100: v = 100;
          PAT_NEG128: v = -128;
          PAT_ZERO:   v = 0;
          default:    v = (l % 2 == 0) ? 120 : -120;  // alternating sign
        endcase
        loaded[r][l] = v;
        l_mod[r][l]  = v;
        wb_write(8'(r * P + l), 32'(v));
      end
    end
  endtask

  task automatic run_decode(input string name);
    logic [31:0] s;
    wb_write(`LDPC_ADR_CTRL, 32'h1);
    wb_read(`LDPC_ADR_STAT, s);
    check_val({name, " busy"}, 32'h0, s);
    do wb_read(`LDPC_ADR_STAT, s); while (s[0] !== 1'b1);  // poll for ready
    model_decode();
  endtask

  task automatic check_results(input string name);
    logic [31:0] got;
    for (int r = 0; r < DEPTH; r++) begin
      for (int l = 0; l < P; l++) begin
        wb_read(8'(r * P + l), got);
        check_val($sformatf("%s r%0d l%0d", name, r, l), 32'(l_mod[r][l]), got);
        if (r == DEPTH - 1 && l >= `LDPC_P_LAST)
          check_val($sformatf("%s masked l%0d", name, l), 32'(loaded[r][l]), got);
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    logic [31:0] rd;
    void'($urandom(32'h23fe_c1f3));
    tests[0] = '{"random", PAT_RANDOM, 1'b0};
    tests[1] = '{"all_pos100", PAT_POS100, 1'b0};
    tests[2] = '{"all_neg128", PAT_NEG128, 1'b0};
    tests[3] = '{"all_zero", PAT_ZERO, 1'b0};
    tests[4] = '{"alt_sign", PAT_ALT, 1'b0};
    tests[5] = '{"abort_reload", PAT_RANDOM, 1'b1};
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // register access, no start
    wb_read(`LDPC_ADR_STAT, rd);
    check_val("reset_status", 32'h0, rd);
    for (int i = 0; i < 4; i++)
      wb_write(8'(i * 5), 32'(i * 37 - 70));
    for (int i = 0; i < 4; i++) begin
      wb_read(8'(i * 5), rd);
      check_val($sformatf("regs word %0d", i * 5), 32'(i * 37 - 70), rd);
    end
    wb_read(8'(WORDS), rd);
    check_val("regs past window", 32'h0, rd);
    wb_read(`LDPC_ADR_CTRL, rd);
    check_val("regs ctrl read", 32'h0, rd);
    wb_read(8'hff, rd);
    check_val("regs unmapped", 32'h0, rd);

    for (int t = 0; t < N_TESTS; t++) begin
      if (tests[t].abort) begin
        load_pattern(PAT_RANDOM);
        wb_write(`LDPC_ADR_CTRL, 32'h1);
        repeat (20) @(posedge clk);   // mid-run
        wb_write(8'h00, 32'h0);       // llr write kills the run
        repeat (RUN_CYC) @(posedge clk);  // past the end of the killed run
        wb_read(`LDPC_ADR_STAT, rd);
        check_val({tests[t].name, " aborted"}, 32'h0, rd);
      end
      load_pattern(tests[t].kind);
      wb_read(`LDPC_ADR_STAT, rd);
      check_val({tests[t].name, " loaded"}, 32'h0, rd);
      run_decode(tests[t].name);
      check_results(tests[t].name);
      // second pass over the results with last run's e memory left in place
      run_decode({tests[t].name, " rerun"});
      check_results({tests[t].name, " rerun"});
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/ldpc_pkg.sv
design/wb_host_if.sv
design/layer_sched.sv
design/llr_mem.sv
design/ext_mem.sv
design/rcu_pipe.sv
design/ldpc_dec_top.sv
tb/ldpc_dec_properties.sv
tb/ldpc_dec_tb.sv
